//--- hw/mmu_pkg.sv
package mmu_pkg;

  // ----------------------------------------
  // address geometry, Sv32
  // ----------------------------------------
  localparam int unsigned VLEN      = 32;
  localparam int unsigned PLEN      = 34;
  // vpn splits into vpn1 (upper half) and vpn0 (lower half)
  localparam int unsigned VPNW      = 20;
  localparam int unsigned PPNW      = 22;
  localparam int unsigned ASIDW     = 9;
  localparam int unsigned PAGE_OFFW = 12;

  // data tlb sizing
  localparam int unsigned TLB_ENTRIES = 4;
  localparam int unsigned TLB_IDXW    = 2;

  // ----------------------------------------
  // pte flag vector, Sv32 bit order
  // ----------------------------------------
  localparam int unsigned PTE_FLAGW = 8;
  localparam int unsigned PTE_V     = 0;
  localparam int unsigned PTE_R     = 1;
  localparam int unsigned PTE_W     = 2;
  localparam int unsigned PTE_X     = 3;
  localparam int unsigned PTE_U     = 4;
  localparam int unsigned PTE_G     = 5;
  localparam int unsigned PTE_A     = 6;
  localparam int unsigned PTE_D     = 7;

  // privilege levels, encoding as in mstatus.mpp
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_lvl_e;

  // config register map
  // ctrl: bit0 translation enable, bit1 sum, bit2 mxr
  typedef enum logic [1:0] {
    CFG_CTRL = 2'd0,
    CFG_PRIV = 2'd1,
    CFG_ASID = 2'd2
  } cfg_addr_e;

  // exception causes reported on the lsu side
  typedef enum logic [3:0] {
    EXC_NONE     = 4'd0,
    EXC_LOAD_PF  = 4'd13,
    EXC_STORE_PF = 4'd15
  } exc_cause_e;

endpackage

//--- hw/mmu_cfg_regs.sv
`timescale 1ns/10ps

module mmu_cfg_regs
  import mmu_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             cfg_we_i,
  input  cfg_addr_e        cfg_addr_i,
  input  logic [VLEN-1:0]  cfg_wdata_i,
  output logic             xlate_en_o,
  output logic             sum_o,
  output logic             mxr_o,
  output priv_lvl_e        priv_o,
  output logic [ASIDW-1:0] asid_o
);

  // ctrl register fields
  logic             ctrl_en_q;
  logic             sum_q;
  logic             mxr_q;
  // current privilege and address space
  priv_lvl_e        priv_q;
  logic [ASIDW-1:0] asid_q;

  // ----------------------------------------
  // register write decode
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_en_q <= 1'b0;
      sum_q     <= 1'b0;
      mxr_q     <= 1'b0;
      priv_q    <= PRIV_U;
      asid_q    <= '0;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        CFG_CTRL: begin
          ctrl_en_q <= cfg_wdata_i[0];
          sum_q     <= cfg_wdata_i[1];
          mxr_q     <= cfg_wdata_i[2];
        end
        // only the low two bits carry the level
        CFG_PRIV: priv_q <= priv_lvl_e'(cfg_wdata_i[1:0]);
        CFG_ASID: asid_q <= cfg_wdata_i[ASIDW-1:0];
        // unmapped address, write is dropped
        default: ;
      endcase
    end
  end

  // machine mode always runs bare, whatever the enable bit says
  assign xlate_en_o = ctrl_en_q && (priv_q != PRIV_M);
  assign sum_o      = sum_q;
  assign mxr_o      = mxr_q;
  assign priv_o     = priv_q;
  assign asid_o     = asid_q;

endmodule

//--- hw/dtlb.sv
`timescale 1ns/10ps

module dtlb
  import mmu_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // software refill
  input  logic                 tlb_we_i,
  input  logic [TLB_IDXW-1:0]  tlb_idx_i,
  input  logic [VPNW-1:0]      tlb_vpn_i,
  input  logic [PPNW-1:0]      tlb_ppn_i,
  input  logic [ASIDW-1:0]     tlb_asid_i,
  input  logic [PTE_FLAGW-1:0] tlb_flags_i,
  input  logic                 tlb_mega_i,
  // sfence style flush
  input  logic                 tlb_flush_i,
  input  logic [VLEN-1:0]      flush_vaddr_i,
  input  logic [ASIDW-1:0]     flush_asid_i,
  // lookup port
  input  logic [VLEN-1:0]      lu_vaddr_i,
  input  logic [ASIDW-1:0]     lu_asid_i,
  output logic                 lu_hit_o,
  output logic [PPNW-1:0]      lu_ppn_o,
  output logic [PTE_FLAGW-1:0] lu_flags_o,
  output logic                 lu_mega_o
);

  // entry storage, only the valid bits are reset
  logic [TLB_ENTRIES-1:0] valid_q;
  logic [TLB_ENTRIES-1:0] mega_q;
  logic [VPNW-1:0]        vpn_q   [TLB_ENTRIES];
  logic [ASIDW-1:0]       asid_q  [TLB_ENTRIES];
  logic [PPNW-1:0]        ppn_q   [TLB_ENTRIES];
  logic [PTE_FLAGW-1:0]   flags_q [TLB_ENTRIES];

  logic [VPNW-1:0]        lu_vpn;
  logic [VPNW-1:0]        flush_vpn;
  logic                   flush_addr_zero;
  logic                   flush_asid_zero;
  logic [TLB_ENTRIES-1:0] lu_match;
  logic [TLB_ENTRIES-1:0] flush_asid_sel;
  logic [TLB_ENTRIES-1:0] flush_addr_sel;
  logic [TLB_ENTRIES-1:0] flush_hit;

  // vpn1 must match, vpn0 only for 4 KiB entries
  function automatic logic page_covers(input logic [VPNW-1:0] tag,
                                       input logic            mega,
                                       input logic [VPNW-1:0] vpn);
    return (tag[VPNW-1:VPNW/2] == vpn[VPNW-1:VPNW/2]) &&
           (mega || (tag[VPNW/2-1:0] == vpn[VPNW/2-1:0]));
  endfunction

  assign lu_vpn    = lu_vaddr_i[VLEN-1:PAGE_OFFW];
  assign flush_vpn = flush_vaddr_i[VLEN-1:PAGE_OFFW];

  // zero operands widen the flush scope
  assign flush_addr_zero = (flush_vaddr_i == '0);
  assign flush_asid_zero = (flush_asid_i == '0);

  // ----------------------------------------
  // lookup, one-hot match then or-select
  // ----------------------------------------
  always_comb begin
    lu_ppn_o   = '0;
    lu_flags_o = '0;
    lu_mega_o  = 1'b0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      // global entries ignore the asid compare
      lu_match[i] = valid_q[i] &&
                    ((asid_q[i] == lu_asid_i) || flags_q[i][PTE_G]) &&
                    page_covers(vpn_q[i], mega_q[i], lu_vpn);
      if (lu_match[i]) begin
        lu_ppn_o   = lu_ppn_o | ppn_q[i];
        lu_flags_o = lu_flags_o | flags_q[i];
        lu_mega_o  = lu_mega_o | mega_q[i];
      end
    end
    lu_hit_o = |lu_match;
  end

  // ----------------------------------------
  // flush selection, four sfence cases
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      // nonzero asid spares global entries and other spaces
      flush_asid_sel[i] = flush_asid_zero ||
                          (!flags_q[i][PTE_G] && (asid_q[i] == flush_asid_i));
      flush_addr_sel[i] = flush_addr_zero || page_covers(vpn_q[i], mega_q[i], flush_vpn);
      flush_hit[i]      = flush_asid_sel[i] && flush_addr_sel[i];
    end
  end

  // valid bits: refill is written last so it beats a flush on its entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      if (tlb_flush_i) begin
        valid_q <= valid_q & ~flush_hit;
      end
      if (tlb_we_i) begin
        valid_q[tlb_idx_i] <= tlb_flags_i[PTE_V];
      end
    end
  end

  // entry contents
  always_ff @(posedge clk_i) begin
    if (tlb_we_i) begin
      vpn_q[tlb_idx_i]   <= tlb_vpn_i;
      asid_q[tlb_idx_i]  <= tlb_asid_i;
      ppn_q[tlb_idx_i]   <= tlb_ppn_i;
      flags_q[tlb_idx_i] <= tlb_flags_i;
      mega_q[tlb_idx_i]  <= tlb_mega_i;
    end
  end

endmodule

//--- hw/lsu_xlate_stage.sv
`timescale 1ns/10ps

module lsu_xlate_stage
  import mmu_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // load/store request
  input  logic                 lsu_req_i,
  input  logic                 lsu_is_store_i,
  input  logic [VLEN-1:0]      lsu_vaddr_i,
  // translation mode from the register block
  input  logic                 xlate_en_i,
  input  logic                 sum_i,
  input  logic                 mxr_i,
  input  priv_lvl_e            priv_i,
  // tlb response, same cycle as the request
  input  logic                 lu_hit_i,
  input  logic [PPNW-1:0]      lu_ppn_i,
  input  logic [PTE_FLAGW-1:0] lu_flags_i,
  input  logic                 lu_mega_i,
  // cycle 0
  output logic                 lsu_dtlb_hit_o,
  output logic                 dtlb_miss_o,
  // cycle 1
  output logic                 lsu_valid_o,
  output logic                 lsu_miss_o,
  output logic                 lsu_ex_valid_o,
  output logic [PLEN-1:0]      lsu_paddr_o,
  output exc_cause_e           lsu_ex_cause_o,
  output logic [VLEN-1:0]      lsu_ex_tval_o
);

  logic                 req_q;
  logic                 is_store_q;
  logic [VLEN-1:0]      vaddr_q;
  logic                 xlate_q;
  logic                 sum_q;
  logic                 mxr_q;
  priv_lvl_e            priv_q;
  logic                 hit_q;
  logic [PPNW-1:0]      ppn_q;
  logic [PTE_FLAGW-1:0] flags_q;
  logic                 mega_q;
  logic                 access_err;
  logic                 page_fault;

  // ----------------------------------------
  // cycle 0
  // ----------------------------------------
  // bare mode is always ready
  assign lsu_dtlb_hit_o = xlate_en_i ? lu_hit_i : 1'b1;
  assign dtlb_miss_o    = lsu_req_i && xlate_en_i && !lu_hit_i;

  // request valid is the only control bit in the stage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else begin
      req_q <= lsu_req_i;
    end
  end

  // capture address, mode and tlb response with the request
  always_ff @(posedge clk_i) begin
    if (lsu_req_i) begin
      is_store_q <= lsu_is_store_i;
      vaddr_q    <= lsu_vaddr_i;
      xlate_q    <= xlate_en_i;
      sum_q      <= sum_i;
      mxr_q      <= mxr_i;
      priv_q     <= priv_i;
      hit_q      <= lu_hit_i;
      ppn_q      <= lu_ppn_i;
      flags_q    <= lu_flags_i;
      mega_q     <= lu_mega_i;
    end
  end

  // ----------------------------------------
  // cycle 1
  // ----------------------------------------
  always_comb begin
    // physical address
    if (!xlate_q) begin
      lsu_paddr_o = {{(PLEN-VLEN){1'b0}}, vaddr_q};
    end else if (mega_q) begin
      // megapage keeps vpn0 and the offset from the virtual address
      lsu_paddr_o = {ppn_q[PPNW-1:VPNW/2], vaddr_q[VPNW/2+PAGE_OFFW-1:0]};
    end else begin
      lsu_paddr_o = {ppn_q, vaddr_q[PAGE_OFFW-1:0]};
    end

    // s mode needs sum for user pages, u mode only sees user pages
    access_err = ((priv_q == PRIV_S) && flags_q[PTE_U] && !sum_q) ||
                 ((priv_q == PRIV_U) && !flags_q[PTE_U]);

    if (is_store_q) begin
      // stores need w and an already dirty page
      page_fault = !flags_q[PTE_W] || !flags_q[PTE_D] || access_err;
    end else begin
      // mxr lets execute-only pages be read
      page_fault = (!flags_q[PTE_R] && !(mxr_q && flags_q[PTE_X])) || access_err;
    end

    // faults only count on a translated hit
    lsu_ex_valid_o = req_q && xlate_q && hit_q && page_fault;
    lsu_miss_o     = req_q && xlate_q && !hit_q;

    if (!lsu_ex_valid_o) begin
      lsu_ex_cause_o = EXC_NONE;
    end else if (is_store_q) begin
      lsu_ex_cause_o = EXC_STORE_PF;
    end else begin
      lsu_ex_cause_o = EXC_LOAD_PF;
    end
  end

  assign lsu_valid_o   = req_q;
  // tval is the faulting virtual address
  assign lsu_ex_tval_o = vaddr_q;

endmodule

//--- hw/mmu_top.sv
`timescale 1ns/10ps

module mmu_top
  import mmu_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // register writes
  input  logic                 cfg_we_i,
  input  cfg_addr_e            cfg_addr_i,
  input  logic [VLEN-1:0]      cfg_wdata_i,
  // tlb refill
  input  logic                 tlb_we_i,
  input  logic [TLB_IDXW-1:0]  tlb_idx_i,
  input  logic [VPNW-1:0]      tlb_vpn_i,
  input  logic [PPNW-1:0]      tlb_ppn_i,
  input  logic [ASIDW-1:0]     tlb_asid_i,
  input  logic [PTE_FLAGW-1:0] tlb_flags_i,
  input  logic                 tlb_mega_i,
  // flush
  input  logic                 tlb_flush_i,
  input  logic [VLEN-1:0]      flush_vaddr_i,
  input  logic [ASIDW-1:0]     flush_asid_i,
  // load/store side
  input  logic                 lsu_req_i,
  input  logic                 lsu_is_store_i,
  input  logic [VLEN-1:0]      lsu_vaddr_i,
  output logic                 lsu_dtlb_hit_o,
  output logic                 dtlb_miss_o,
  output logic                 lsu_valid_o,
  output logic                 lsu_miss_o,
  output logic                 lsu_ex_valid_o,
  output logic [PLEN-1:0]      lsu_paddr_o,
  output exc_cause_e           lsu_ex_cause_o,
  output logic [VLEN-1:0]      lsu_ex_tval_o
);

  // register block to tlb and stage
  logic                 xlate_en;
  logic                 sum;
  logic                 mxr;
  priv_lvl_e            priv;
  logic [ASIDW-1:0]     asid;
  // tlb lookup response
  logic                 lu_hit;
  logic [PPNW-1:0]      lu_ppn;
  logic [PTE_FLAGW-1:0] lu_flags;
  logic                 lu_mega;

  mmu_cfg_regs u_cfg_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .xlate_en_o  (xlate_en),
    .sum_o       (sum),
    .mxr_o       (mxr),
    .priv_o      (priv),
    .asid_o      (asid)
  );

  // lookup runs on the live request address and current asid
  dtlb u_dtlb (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .tlb_we_i      (tlb_we_i),
    .tlb_idx_i     (tlb_idx_i),
    .tlb_vpn_i     (tlb_vpn_i),
    .tlb_ppn_i     (tlb_ppn_i),
    .tlb_asid_i    (tlb_asid_i),
    .tlb_flags_i   (tlb_flags_i),
    .tlb_mega_i    (tlb_mega_i),
    .tlb_flush_i   (tlb_flush_i),
    .flush_vaddr_i (flush_vaddr_i),
    .flush_asid_i  (flush_asid_i),
    .lu_vaddr_i    (lsu_vaddr_i),
    .lu_asid_i     (asid),
    .lu_hit_o      (lu_hit),
    .lu_ppn_o      (lu_ppn),
    .lu_flags_o    (lu_flags),
    .lu_mega_o     (lu_mega)
  );

  lsu_xlate_stage u_xlate (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_req_i      (lsu_req_i),
    .lsu_is_store_i (lsu_is_store_i),
    .lsu_vaddr_i    (lsu_vaddr_i),
    .xlate_en_i     (xlate_en),
    .sum_i          (sum),
    .mxr_i          (mxr),
    .priv_i         (priv),
    .lu_hit_i       (lu_hit),
    .lu_ppn_i       (lu_ppn),
    .lu_flags_i     (lu_flags),
    .lu_mega_i      (lu_mega),
    .lsu_dtlb_hit_o (lsu_dtlb_hit_o),
    .dtlb_miss_o    (dtlb_miss_o),
    .lsu_valid_o    (lsu_valid_o),
    .lsu_miss_o     (lsu_miss_o),
    .lsu_ex_valid_o (lsu_ex_valid_o),
    .lsu_paddr_o    (lsu_paddr_o),
    .lsu_ex_cause_o (lsu_ex_cause_o),
    .lsu_ex_tval_o  (lsu_ex_tval_o)
  );

endmodule

//--- dv/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // reset low over the first two rising edges
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

//--- dv/mmu_tb.sv
`timescale 1ns/10ps

module mmu_tb
  import mmu_pkg::*;
();

  localparam int MAX_CYCLES = 2000;
  // v r w a d, plus the same with g
  localparam logic [PTE_FLAGW-1:0] FLAGS_RW = 8'hC7;
  localparam logic [PTE_FLAGW-1:0] FLAGS_G  = 8'hE7;

  logic clk, rst_n;
  logic cfg_we, tlb_we, tlb_mega, tlb_flush, lsu_req, lsu_is_store;
  cfg_addr_e cfg_addr;
  logic [VLEN-1:0] cfg_wdata, flush_vaddr, lsu_vaddr;
  logic [TLB_IDXW-1:0] tlb_idx;
  logic [VPNW-1:0] tlb_vpn;
  logic [PPNW-1:0] tlb_ppn;
  logic [ASIDW-1:0] tlb_asid, flush_asid;
  logic [PTE_FLAGW-1:0] tlb_flags;
  logic lsu_dtlb_hit, dtlb_miss, lsu_valid, lsu_miss, lsu_ex_valid;
  logic [PLEN-1:0] lsu_paddr;
  exc_cause_e lsu_ex_cause;
  logic [VLEN-1:0] lsu_ex_tval;

  // reference model of the tlb and the config registers
  logic [TLB_ENTRIES-1:0] ref_valid, ref_mega;
  logic [VPNW-1:0] ref_vpn [TLB_ENTRIES];
  logic [PPNW-1:0] ref_ppn [TLB_ENTRIES];
  logic [ASIDW-1:0] ref_asid [TLB_ENTRIES];
  logic [PTE_FLAGW-1:0] ref_flags [TLB_ENTRIES];
  logic cur_en, cur_sum, cur_mxr;
  priv_lvl_e cur_priv;
  logic [ASIDW-1:0] cur_asid;

  // expected results, one entry per request in flight
  logic exp_miss_q [$];
  exc_cause_e exp_cause_q [$];
  logic [PLEN-1:0] exp_paddr_q [$];
  logic [VLEN-1:0] exp_tval_q [$];

  logic [15:0] lfsr;
  int cycle_cnt = 0;

  tb_clkgen u_clkgen (.clk_o(clk), .rst_no(rst_n));

  mmu_top dut (
    .clk_i(clk), .rst_ni(rst_n),
    .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata),
    .tlb_we_i(tlb_we), .tlb_idx_i(tlb_idx), .tlb_vpn_i(tlb_vpn), .tlb_ppn_i(tlb_ppn),
    .tlb_asid_i(tlb_asid), .tlb_flags_i(tlb_flags), .tlb_mega_i(tlb_mega),
    .tlb_flush_i(tlb_flush), .flush_vaddr_i(flush_vaddr), .flush_asid_i(flush_asid),
    .lsu_req_i(lsu_req), .lsu_is_store_i(lsu_is_store), .lsu_vaddr_i(lsu_vaddr),
    .lsu_dtlb_hit_o(lsu_dtlb_hit), .dtlb_miss_o(dtlb_miss), .lsu_valid_o(lsu_valid),
    .lsu_miss_o(lsu_miss), .lsu_ex_valid_o(lsu_ex_valid), .lsu_paddr_o(lsu_paddr),
    .lsu_ex_cause_o(lsu_ex_cause), .lsu_ex_tval_o(lsu_ex_tval)
  );

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  // ----------------------------------------
  // random source, galois lfsr x^16+x^14+x^13+x^11+1
  // ----------------------------------------
  function automatic logic lfsr_step();
    logic out_bit;
    out_bit = lfsr[0];
    lfsr = lfsr >> 1;
    if (out_bit) lfsr = lfsr ^ 16'hB400;
    return out_bit;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) r = {r[30:0], lfsr_step()};
    return r;
  endfunction

  function automatic logic [PPNW-1:0] rand_ppn();
    logic [31:0] r;
    r = rand_bits(PPNW);
    return r[PPNW-1:0];
  endfunction

  // low two bits of vpn1 hold the index, so entries never overlap
  function automatic logic [VPNW-1:0] entry_vpn(input int idx);
    logic [31:0] hi, lo;
    hi = rand_bits(8);
    lo = rand_bits(10);
    return {hi[7:0], TLB_IDXW'(idx), lo[9:0]};
  endfunction

  // ----------------------------------------
  // reference helpers
  // ----------------------------------------
  function automatic logic covers(input int i, input logic [VPNW-1:0] vpn);
    return (ref_vpn[i][19:10] == vpn[19:10]) && (ref_mega[i] || ref_vpn[i][9:0] == vpn[9:0]);
  endfunction

  function automatic int ref_lookup(input logic [VLEN-1:0] va);
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (ref_valid[i] && (ref_asid[i] == cur_asid || ref_flags[i][PTE_G]) &&
          covers(i, va[31:12])) return i;
    end
    return -1;
  endfunction

  // random address inside the page of one entry
  function automatic logic [VLEN-1:0] page_va(input int idx);
    logic [31:0] r;
    r = rand_bits(ref_mega[idx] ? 22 : 12);
    return ref_mega[idx] ? {ref_vpn[idx][19:10], r[21:0]} : {ref_vpn[idx], r[11:0]};
  endfunction

  task automatic clear_strobes();
    cfg_we = 1'b0;
    tlb_we = 1'b0;
    tlb_flush = 1'b0;
    lsu_req = 1'b0;
  endtask

  task automatic write_cfg(input cfg_addr_e addr, input logic [VLEN-1:0] data);
    @(posedge clk);
    #1;
    clear_strobes();
    cfg_we = 1'b1;
    cfg_addr = addr;
    cfg_wdata = data;
    case (addr)
      CFG_CTRL: {cur_mxr, cur_sum, cur_en} = data[2:0];
      CFG_PRIV: cur_priv = priv_lvl_e'(data[1:0]);
      CFG_ASID: cur_asid = data[ASIDW-1:0];
      default: ;
    endcase
  endtask

  task automatic refill(input int idx, input logic [VPNW-1:0] vpn, input logic [PPNW-1:0] ppn,
                        input logic [ASIDW-1:0] asid, input logic [PTE_FLAGW-1:0] flags,
                        input logic mega);
    @(posedge clk);
    #1;
    clear_strobes();
    tlb_we = 1'b1;
    tlb_idx = TLB_IDXW'(idx);
    {tlb_vpn, tlb_ppn, tlb_asid, tlb_flags, tlb_mega} = {vpn, ppn, asid, flags, mega};
    // v clear leaves the entry invalid
    ref_valid[idx] = flags[PTE_V];
    ref_vpn[idx] = vpn;
    ref_ppn[idx] = ppn;
    ref_asid[idx] = asid;
    ref_flags[idx] = flags;
    ref_mega[idx] = mega;
  endtask

  task automatic flush(input logic [VLEN-1:0] va, input logic [ASIDW-1:0] asid);
    @(posedge clk);
    #1;
    clear_strobes();
    tlb_flush = 1'b1;
    flush_vaddr = va;
    flush_asid = asid;
    // zero operands widen the scope, nonzero asid spares global entries
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if ((asid == '0 || (!ref_flags[i][PTE_G] && ref_asid[i] == asid)) &&
          (va == '0 || covers(i, va[31:12]))) ref_valid[i] = 1'b0;
    end
  endtask

  // drive one request, check cycle 0 and queue the cycle 1 result
  task automatic send_req(input logic store, input logic [VLEN-1:0] va);
    int idx;
    logic xl, acc_err, fault;
    logic [PTE_FLAGW-1:0] f;
    exc_cause_e cause;
    logic [PLEN-1:0] pa;
    @(posedge clk);
    #1;
    clear_strobes();
    lsu_req = 1'b1;
    lsu_is_store = store;
    lsu_vaddr = va;
    xl = cur_en && (cur_priv != PRIV_M);
    idx = xl ? ref_lookup(va) : -1;
    cause = EXC_NONE;
    pa = {2'b00, va};
    if (xl && idx >= 0) begin
      f = ref_flags[idx];
      pa = ref_mega[idx] ? {ref_ppn[idx][21:10], va[21:0]} : {ref_ppn[idx], va[11:0]};
      acc_err = (cur_priv == PRIV_S && f[PTE_U] && !cur_sum) || (cur_priv == PRIV_U && !f[PTE_U]);
      if (store) fault = !f[PTE_W] || !f[PTE_D] || acc_err;
      else fault = (!f[PTE_R] && !(cur_mxr && f[PTE_X])) || acc_err;
      if (fault) cause = store ? EXC_STORE_PF : EXC_LOAD_PF;
    end
    exp_miss_q.push_back(xl && idx < 0);
    exp_cause_q.push_back(cause);
    exp_paddr_q.push_back(pa);
    exp_tval_q.push_back(va);
    #1;
    assert (lsu_dtlb_hit == (!xl || idx >= 0) && dtlb_miss == (xl && idx < 0))
      else report_fail($sformatf("mismatch at %0t: cycle 0 hit %b miss %b for va %h",
                                 $time, lsu_dtlb_hit, dtlb_miss, va));
  endtask

  task automatic drain();
    @(posedge clk);
    #1;
    clear_strobes();
    // past the cycle 1 check of the last request
    #2;
  endtask

  // ----------------------------------------
  // cycle 1 result check
  // ----------------------------------------
  always @(posedge clk) begin : result_check
    logic had_req, e_miss;
    exc_cause_e e_cause;
    logic [PLEN-1:0] e_paddr;
    logic [VLEN-1:0] e_tval;
    had_req = lsu_req;
    #2;
    if (had_req) begin
      e_miss = exp_miss_q.pop_front();
      e_cause = exp_cause_q.pop_front();
      e_paddr = exp_paddr_q.pop_front();
      e_tval = exp_tval_q.pop_front();
      assert (lsu_valid && lsu_miss == e_miss && lsu_ex_valid == (e_cause != EXC_NONE) &&
              lsu_ex_cause == e_cause && lsu_ex_tval == e_tval)
        else report_fail($sformatf("mismatch at %0t: v%b m%b c%0d tval %h, exp m%b c%0d tval %h",
                                   $time, lsu_valid, lsu_miss, lsu_ex_cause, lsu_ex_tval,
                                   e_miss, e_cause, e_tval));
      // the address is meaningless on a miss
      if (!e_miss) begin
        assert (lsu_paddr == e_paddr)
          else report_fail($sformatf("mismatch at %0t: paddr %h, exp %h",
                                     $time, lsu_paddr, e_paddr));
      end
    end else begin
      assert (!lsu_valid && !lsu_miss && !lsu_ex_valid)
        else report_fail($sformatf("mismatch at %0t: result outputs active with no request", $time));
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) report_fail("timeout, the tests did not finish in time");
  end

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic bare_mode_test();
    // reset leaves user mode with translation off
    repeat (8) send_req(lfsr_step(), rand_bits(32));
    write_cfg(CFG_PRIV, 32'd3);
    write_cfg(CFG_CTRL, 32'd1);
    repeat (8) send_req(lfsr_step(), rand_bits(32));
    drain();
  endtask

  task automatic translate_test();
    write_cfg(CFG_PRIV, 32'd1);
    write_cfg(CFG_ASID, 32'd5);
    refill(0, entry_vpn(0), rand_ppn(), 9'd5, FLAGS_RW, 1'b0);
    refill(1, entry_vpn(1), rand_ppn(), 9'd5, FLAGS_RW, 1'b1);
    for (int k = 0; k < 8; k++) send_req(lfsr_step(), page_va(k % 2));
    drain();
  endtask

  task automatic perm_test();
    logic [31:0] r;
    logic [PTE_FLAGW-1:0] flags;
    for (int k = 0; k < 8; k++) begin
      // random d u x w r, v and a always set
      r = rand_bits(5);
      flags = {r[4], 1'b1, 1'b0, r[3], r[2], r[1], r[0], 1'b1};
      refill(2, entry_vpn(2), rand_ppn(), 9'd5, flags, lfsr_step());
      for (int p = 0; p < 2; p++) begin
        write_cfg(CFG_PRIV, p);
        // sweep sum and mxr with translation on
        for (int c = 0; c < 4; c++) begin
          write_cfg(CFG_CTRL, c * 2 + 1);
          send_req(1'b0, page_va(2));
          send_req(1'b1, page_va(2));
        end
      end
    end
    drain();
  endtask

  task automatic miss_asid_test();
    write_cfg(CFG_PRIV, 32'd1);
    write_cfg(CFG_CTRL, 32'd1);
    refill(0, entry_vpn(0), rand_ppn(), 9'd5, FLAGS_RW, 1'b0);
    refill(1, entry_vpn(1), rand_ppn(), 9'd9, FLAGS_G, 1'b1);
    refill(3, entry_vpn(3), rand_ppn(), 9'd5, 8'h00, 1'b0);
    // asid 7 misses entry 0, the global entry hits under both
    for (int a = 5; a <= 7; a += 2) begin
      write_cfg(CFG_ASID, a);
      send_req(1'b0, page_va(0));
      send_req(1'b1, page_va(1));
      send_req(1'b0, page_va(3));
    end
    drain();
  endtask

  task automatic flush_layout();
    refill(0, 20'h12345, rand_ppn(), 9'd5, FLAGS_RW, 1'b0);
    refill(1, 20'h24000, rand_ppn(), 9'd5, FLAGS_G, 1'b1);
    refill(2, 20'h36001, rand_ppn(), 9'd7, FLAGS_RW, 1'b0);
    refill(3, 20'h36002, rand_ppn(), 9'd7, FLAGS_RW, 1'b0);
  endtask

  task automatic lookup_all();
    write_cfg(CFG_ASID, 32'd5);
    send_req(1'b0, page_va(0));
    send_req(1'b0, page_va(1));
    write_cfg(CFG_ASID, 32'd7);
    for (int i = 1; i < TLB_ENTRIES; i++) send_req(1'b0, page_va(i));
    drain();
  endtask

  task automatic flush_test();
    flush_layout();
    flush(32'h0, 9'd0);
    lookup_all();
    flush_layout();
    flush(32'h0, 9'd7);
    lookup_all();
    // address only, entry 3 shares vpn1 but not vpn0
    flush_layout();
    flush({20'h36001, 12'h000}, 9'd0);
    lookup_all();
    flush_layout();
    flush({20'h243FF, 12'hABC}, 9'd0);
    lookup_all();
    flush_layout();
    flush({20'h12345, 12'h000}, 9'd5);
    lookup_all();
    // a global megapage survives a flush naming its own asid
    flush_layout();
    flush({20'h24000, 12'h000}, 9'd5);
    lookup_all();
  endtask

  task automatic pipeline_test();
    flush_layout();
    // read-only page under the current asid, stores fault
    refill(3, 20'h36002, rand_ppn(), 9'd5, 8'h43, 1'b0);
    write_cfg(CFG_ASID, 32'd5);
    repeat (16) send_req(lfsr_step(), page_va(rand_bits(2)));
    drain();
  endtask

  initial begin
    lfsr = 16'd47812;
    clear_strobes();
    cfg_addr = CFG_CTRL;
    {cfg_wdata, flush_vaddr, lsu_vaddr, lsu_is_store} = '0;
    {tlb_idx, tlb_vpn, tlb_ppn, tlb_asid, tlb_flags, tlb_mega, flush_asid} = '0;
    {ref_valid, ref_mega, cur_en, cur_sum, cur_mxr, cur_asid} = '0;
    cur_priv = PRIV_U;
    @(posedge rst_n);
    bare_mode_test();
    translate_test();
    perm_test();
    miss_asid_test();
    flush_test();
    pipeline_test();
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- project.f
hw/mmu_pkg.sv
hw/mmu_cfg_regs.sv
hw/dtlb.sv
hw/lsu_xlate_stage.sv
hw/mmu_top.sv
dv/tb_clkgen.sv
dv/mmu_tb.sv
